/* source/dram_pkg.sv */
`default_nettype none

// burst memory port, one 64-bit beat per accepted cycle
package dram_pkg;

    localparam int unsigned ADDR_BITS      = 32;
    localparam int unsigned BEAT_BITS      = 64;
    localparam int unsigned BEATS_PER_LINE = 4;

    typedef logic [BEAT_BITS-1:0] beat_t;

    // adaptor to memory
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic                 read;
        logic                 write;
        beat_t                wdata;
    } bmem_cmd_t;

    // memory to adaptor, raddr tags each returned beat with its line
    typedef struct packed {
        logic                 ready;
        logic [ADDR_BITS-1:0] raddr;
        beat_t                rdata;
        logic                 rvalid;
    } bmem_rsp_t;

endpackage

`default_nettype wire

/* source/line_pkg.sv */
`default_nettype none

// cache-line side shared by both requesters and the adaptor
package line_pkg;

    localparam int unsigned LINE_BITS = dram_pkg::BEAT_BITS * dram_pkg::BEATS_PER_LINE;

    // beat 0 sits in the low bits
    typedef dram_pkg::beat_t [dram_pkg::BEATS_PER_LINE-1:0] line_t;

    // read and write are levels, held until resp
    typedef struct packed {
        logic [dram_pkg::ADDR_BITS-1:0] addr;
        logic                           read;
        logic                           write;
        line_t                          wdata;
    } line_req_t;

    // resp is a single-cycle pulse
    typedef struct packed {
        line_t rdata;
        logic  resp;
    } line_rsp_t;

    typedef enum logic {
        REQ_INSN = 1'b0,
        REQ_DATA = 1'b1
    } requester_e;

endpackage

`default_nettype wire

/* source/line_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module line_arbiter #(
    parameter bit DATA_FIRST = 1'b1
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_flush,

    input  wire line_pkg::line_req_t i_insn_req,
    output line_pkg::line_rsp_t      o_insn_rsp,

    input  wire line_pkg::line_req_t i_data_req,
    output line_pkg::line_rsp_t      o_data_rsp,

    output line_pkg::line_req_t      o_port_req,
    input  wire line_pkg::line_rsp_t i_port_rsp
);

    import line_pkg::*;

    logic       busy_q;
    requester_e owner_q;
    logic       cancel_q;
    line_req_t  req_q;

    logic       insn_want;
    logic       data_want;
    logic       grant_valid;
    requester_e grant_owner;
    logic       insn_owns;
    logic       data_owns;

    // a fetch dropped by the flush in this cycle is not granted
    assign insn_want = i_insn_req.read & ~i_flush;
    assign data_want = i_data_req.read | i_data_req.write;

    always_comb begin
        grant_valid = insn_want | data_want;
        if (insn_want && data_want) begin
            grant_owner = DATA_FIRST ? REQ_DATA : REQ_INSN;
        end else if (data_want) begin
            grant_owner = REQ_DATA;
        end else begin
            grant_owner = REQ_INSN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= 1'b0;
            owner_q  <= REQ_INSN;
            cancel_q <= 1'b0;
        end else if (!busy_q) begin
            if (grant_valid) begin
                busy_q  <= 1'b1;
                owner_q <= grant_owner;
            end
        end else if (i_port_rsp.resp) begin
            // transaction over, swallowed or not
            busy_q   <= 1'b0;
            cancel_q <= 1'b0;
        end else if (i_flush && owner_q == REQ_INSN) begin
            cancel_q <= 1'b1;
        end
    end

    // the winner's request, frozen for the whole transaction
    always_ff @(posedge clk) begin
        if (!busy_q && grant_valid) begin
            if (grant_owner == REQ_DATA) begin
                req_q <= i_data_req;
            end else begin
                req_q <= i_insn_req;
            end
        end
    end

    // a cancelled fetch keeps running on the port until its resp
    always_comb begin
        o_port_req       = req_q;
        o_port_req.read  = busy_q & req_q.read;
        o_port_req.write = busy_q & req_q.write;
    end

    assign insn_owns = busy_q && owner_q == REQ_INSN;
    assign data_owns = busy_q && owner_q == REQ_DATA;

    // the instruction side never sees the resp of a flushed fetch
    always_comb begin
        o_insn_rsp.resp  = insn_owns & i_port_rsp.resp & ~cancel_q & ~i_flush;
        o_insn_rsp.rdata = insn_owns ? i_port_rsp.rdata : '0;
        o_data_rsp.resp  = data_owns & i_port_rsp.resp;
        o_data_rsp.rdata = data_owns ? i_port_rsp.rdata : '0;
    end

endmodule

`default_nettype wire

/* source/burst_adaptor.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_adaptor (
    input  wire                      clk,
    input  wire                      rst,

    input  wire line_pkg::line_req_t i_line_req,
    output line_pkg::line_rsp_t      o_line_rsp,

    output dram_pkg::bmem_cmd_t      o_bmem_cmd,
    input  wire dram_pkg::bmem_rsp_t i_bmem_rsp
);

    import dram_pkg::*;
    import line_pkg::*;

    localparam int unsigned CNT_BITS = $clog2(BEATS_PER_LINE);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE_BEATS,
        ST_READ_ISSUE,
        ST_READ_COLLECT,
        ST_DONE
    } state_e;

    state_e               state_q;
    logic [CNT_BITS-1:0]  beat_cnt_q;
    logic                 resp_q;
    logic [LINE_BITS-1:0] line_q;

    logic                 last_beat;
    logic                 req_active;

    assign last_beat  = beat_cnt_q == CNT_BITS'(BEATS_PER_LINE - 1);
    assign req_active = i_line_req.read | i_line_req.write;

    // address and write data come straight from the held line request
    always_comb begin
        o_bmem_cmd.addr  = i_line_req.addr;
        o_bmem_cmd.read  = state_q == ST_READ_ISSUE;
        o_bmem_cmd.write = state_q == ST_WRITE_BEATS;
        o_bmem_cmd.wdata = i_line_req.wdata[beat_cnt_q];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            beat_cnt_q <= '0;
            resp_q     <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    beat_cnt_q <= '0;
                    if (i_line_req.write) begin
                        state_q <= ST_WRITE_BEATS;
                    end else if (i_line_req.read) begin
                        state_q <= ST_READ_ISSUE;
                    end
                end
                ST_WRITE_BEATS: begin
                    // beat only advances when memory takes it
                    if (i_bmem_rsp.ready) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (last_beat) begin
                            resp_q  <= 1'b1;
                            state_q <= ST_DONE;
                        end
                    end
                end
                ST_READ_ISSUE: begin
                    if (i_bmem_rsp.ready) begin
                        state_q <= ST_READ_COLLECT;
                    end
                end
                ST_READ_COLLECT: begin
                    if (i_bmem_rsp.rvalid) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (last_beat) begin
                            resp_q  <= 1'b1;
                            state_q <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    // hold off until the requester lets go
                    if (!req_active) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // beats shift in from the top, so beat 0 ends up lowest
    always_ff @(posedge clk) begin
        if (state_q == ST_READ_COLLECT && i_bmem_rsp.rvalid) begin
            line_q <= {i_bmem_rsp.rdata, line_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

    always_comb begin
        o_line_rsp.resp  = resp_q;
        o_line_rsp.rdata = line_t'(line_q);
    end

endmodule

`default_nettype wire

/* source/dram_line_port.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_line_port #(
    parameter bit DATA_FIRST = 1'b1
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_flush,

    input  wire line_pkg::line_req_t i_insn_req,
    output line_pkg::line_rsp_t      o_insn_rsp,
    input  wire line_pkg::line_req_t i_data_req,
    output line_pkg::line_rsp_t      o_data_rsp,

    output dram_pkg::bmem_cmd_t      o_bmem_cmd,
    input  wire dram_pkg::bmem_rsp_t i_bmem_rsp
);

    import line_pkg::*;

    // single line transaction between arbiter and adaptor
    line_req_t port_req;
    line_rsp_t port_rsp;

    line_arbiter #(
        .DATA_FIRST (DATA_FIRST)
    ) u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .i_flush    (i_flush),
        .i_insn_req (i_insn_req),
        .o_insn_rsp (o_insn_rsp),
        .i_data_req (i_data_req),
        .o_data_rsp (o_data_rsp),
        .o_port_req (port_req),
        .i_port_rsp (port_rsp)
    );

    burst_adaptor u_adaptor (
        .clk        (clk),
        .rst        (rst),
        .i_line_req (port_req),
        .o_line_rsp (port_rsp),
        .o_bmem_cmd (o_bmem_cmd),
        .i_bmem_rsp (i_bmem_rsp)
    );

endmodule

`default_nettype wire

/* verification/bmem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module bmem_model #(
    parameter int unsigned READ_DELAY = 3
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_ready,
    input  wire dram_pkg::bmem_cmd_t i_cmd,
    output dram_pkg::bmem_rsp_t      o_rsp
);

    import dram_pkg::*;

    // written beats, keyed by byte address
    beat_t                mem [logic [ADDR_BITS-1:0]];
    logic [1:0]           wr_beat;
    logic                 rd_busy;
    logic [1:0]           rd_beat;
    int unsigned          rd_wait;
    logic [ADDR_BITS-1:0] rd_addr;
    logic                 rvalid_q;
    beat_t                rdata_q;

    // an unwritten beat holds its address over its complement
    function automatic beat_t read_beat(input logic [ADDR_BITS-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {addr, ~addr};
    endfunction

    always @(posedge clk) begin
        if (!rst && i_ready && i_cmd.write) begin
            mem[i_cmd.addr + 32'({wr_beat, 3'b000})] = i_cmd.wdata;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wr_beat  <= '0;
            rd_busy  <= 1'b0;
            rd_beat  <= '0;
            rd_wait  <= 0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= 1'b0;
            if (i_ready && i_cmd.write) begin
                wr_beat <= wr_beat + 2'd1;
            end
            if (!rd_busy) begin
                if (i_ready && i_cmd.read) begin
                    rd_busy <= 1'b1;
                    rd_addr <= i_cmd.addr;
                    rd_wait <= READ_DELAY;
                    rd_beat <= '0;
                end
            end else if (rd_wait != 0) begin
                rd_wait <= rd_wait - 1;
            end else begin
                // four beats back to back, beat 0 first
                rvalid_q <= 1'b1;
                rdata_q  <= read_beat(rd_addr + 32'({rd_beat, 3'b000}));
                rd_beat  <= rd_beat + 2'd1;
                rd_busy  <= rd_beat != 2'd3;
            end
        end
    end

    always_comb begin
        o_rsp.ready  = i_ready;
        o_rsp.raddr  = rd_addr;
        o_rsp.rdata  = rdata_q;
        o_rsp.rvalid = rvalid_q;
    end

endmodule

`default_nettype wire

/* verification/tb_dram_line_port.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dram_line_port;

    import dram_pkg::*;
    import line_pkg::*;

    localparam int          TIMEOUT    = 200;
    localparam int unsigned READ_DELAY = 3;
    localparam logic [31:0] SEED       = 32'h0fc9_299d;
    localparam int          N_TESTS    = 9;

    // flush_after counts cycles from the request and 0 means no flush
    typedef struct packed {
        logic        insn;
        logic        data;
        logic        write;
        logic [31:0] insn_addr;
        logic [31:0] data_addr;
        logic [3:0]  flush_after;
        logic        rand_ready;
    } row_t;

    // insn, data, write, insn_addr, data_addr, flush_after, rand_ready
    row_t tests [N_TESTS] = '{
        '{1'b1, 1'b0, 1'b0, 32'h0000_1000, 32'h0000_0000, 4'd0, 1'b0},
        '{1'b0, 1'b1, 1'b1, 32'h0000_0000, 32'h0000_2000, 4'd0, 1'b0},
        '{1'b0, 1'b1, 1'b0, 32'h0000_0000, 32'h0000_2000, 4'd0, 1'b0},
        '{1'b1, 1'b1, 1'b0, 32'h0000_3000, 32'h0000_2000, 4'd0, 1'b0},
        '{1'b1, 1'b0, 1'b0, 32'h0000_4000, 32'h0000_0000, 4'd2, 1'b0},
        '{1'b1, 1'b0, 1'b0, 32'h0000_4020, 32'h0000_0000, 4'd0, 1'b0},
        '{1'b0, 1'b1, 1'b1, 32'h0000_0000, 32'h0000_5040, 4'd0, 1'b1},
        '{1'b0, 1'b1, 1'b0, 32'h0000_0000, 32'h0000_5040, 4'd0, 1'b1},
        '{1'b1, 1'b0, 1'b0, 32'h0000_6060, 32'h0000_0000, 4'd0, 1'b1}
    };

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    logic        ready;
    line_req_t   insn_req;
    line_req_t   data_req;
    line_rsp_t   insn_rsp;
    line_rsp_t   data_rsp;
    bmem_cmd_t   bmem_cmd;
    bmem_rsp_t   bmem_rsp;

    logic [31:0] lfsr = SEED;
    int          errors = 0;
    int          failed = 0;
    int          n_run = 0;
    logic        timed_out = 1'b0;
    int          insn_resps = 0;
    int          data_resps = 0;
    int          rd_beats = 0;
    logic [31:0] wr_addr_log [$];
    beat_t       wr_data_log [$];
    line_t       shadow [logic [31:0]];

    dram_line_port #(
        .DATA_FIRST (1'b1)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .i_flush    (flush),
        .i_insn_req (insn_req),
        .o_insn_rsp (insn_rsp),
        .i_data_req (data_req),
        .o_data_rsp (data_rsp),
        .o_bmem_cmd (bmem_cmd),
        .i_bmem_rsp (bmem_rsp)
    );

    bmem_model #(
        .READ_DELAY (READ_DELAY)
    ) u_mem (
        .clk     (clk),
        .rst     (rst),
        .i_ready (ready),
        .i_cmd   (bmem_cmd),
        .o_rsp   (bmem_rsp)
    );

    always #2 clk = ~clk;

    // beats and responses as they cross the ports
    always @(posedge clk) begin
        if (!rst) begin
            if (bmem_cmd.write && bmem_rsp.ready) begin
                wr_addr_log.push_back(bmem_cmd.addr);
                wr_data_log.push_back(bmem_cmd.wdata);
            end
            rd_beats   += int'(bmem_rsp.rvalid);
            insn_resps += int'(insn_rsp.resp);
            data_resps += int'(data_rsp.resp);
        end
    end

    // Galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return bits;
    endfunction

    // beat k of line A holds A+8k above its complement
    function automatic line_t rule_line(input logic [31:0] addr);
        line_t       result;
        logic [31:0] ba;
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            ba        = addr + 32'(8 * k);
            result[k] = {ba, ~ba};
        end
        return result;
    endfunction

    function automatic line_t expected_line(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return rule_line(addr);
    endfunction

    task automatic check_line(input int idx, input string name,
                              input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("[ERROR] test %0d %s: got %h expected %h", idx, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_value(input int idx, input string name,
                               input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] test %0d %s: got %h expected %h", idx, name, got, exp);
            errors++;
        end
    endtask

    task automatic run_test(input int idx, input row_t t);
        line_t wdata;
        line_t exp_i;
        line_t exp_d;
        logic  pend_i;
        logic  pend_d;
        int    cycles;
        int    err0;
        int    ins0;
        int    dat0;
        int    rd0;
        int    wr0;
        err0 = errors;
        ins0 = insn_resps;
        dat0 = data_resps;
        rd0  = rd_beats;
        wr0  = wr_addr_log.size();
        n_run++;
        wdata = '0;
        if (t.data && t.write) begin
            for (int k = 0; k < BEATS_PER_LINE; k++) begin
                wdata[k][63:32] = take_bits(32);
                wdata[k][31:0]  = take_bits(32);
            end
        end
        exp_i = expected_line(t.insn_addr);
        exp_d = expected_line(t.data_addr);
        insn_req.addr  = t.insn_addr;
        insn_req.read  = t.insn;
        data_req.addr  = t.data_addr;
        data_req.read  = t.data & ~t.write;
        data_req.write = t.data & t.write;
        data_req.wdata = wdata;
        pend_i = t.insn && t.flush_after == 0;
        pend_d = t.data;
        cycles = 0;
        // a flushed fetch is watched for the whole window
        while (cycles < TIMEOUT && (pend_i || pend_d || t.flush_after != 0)) begin
            @(negedge clk);
            cycles++;
            // responses are sampled before any input moves
            if (insn_rsp.resp && pend_i) begin
                pend_i        = 1'b0;
                insn_req.read = 1'b0;
                if (pend_d) begin
                    $display("test %0d: instruction resp arrived before data resp", idx);
                    errors++;
                end
                check_line(idx, "o_insn_rsp.rdata", insn_rsp.rdata, exp_i);
            end
            if (data_rsp.resp && pend_d) begin
                pend_d         = 1'b0;
                data_req.read  = 1'b0;
                data_req.write = 1'b0;
                if (!t.write) begin
                    check_line(idx, "o_data_rsp.rdata", data_rsp.rdata, exp_d);
                end
            end
            ready = t.rand_ready ? (take_bits(1) != 0) : 1'b1;
            flush = t.flush_after != 0 && cycles == int'(t.flush_after);
            if (flush) begin
                insn_req.read = 1'b0;
            end
        end
        flush = 1'b0;
        ready = 1'b1;
        if (pend_i || pend_d) begin
            $display("test %0d: no line response within %0d cycles", idx, TIMEOUT);
            timed_out = 1'b1;
            errors++;
        end
        repeat (4) @(negedge clk);
        check_value(idx, "o_insn_rsp.resp count", 64'(insn_resps - ins0),
                    64'(t.insn && t.flush_after == 0));
        check_value(idx, "o_data_rsp.resp count", 64'(data_resps - dat0), 64'(t.data));
        check_value(idx, "i_bmem_rsp.rvalid count", 64'(rd_beats - rd0),
                    64'(4 * (int'(t.insn) + int'(t.data && !t.write))));
        check_value(idx, "o_bmem_cmd.write count", 64'(wr_addr_log.size() - wr0),
                    (t.data && t.write) ? 64'd4 : 64'd0);
        if (t.data && t.write) begin
            for (int k = 0; k < BEATS_PER_LINE && wr0 + k < wr_addr_log.size(); k++) begin
                check_value(idx, "o_bmem_cmd.addr", 64'(wr_addr_log[wr0 + k]),
                            64'(t.data_addr));
                check_value(idx, "o_bmem_cmd.wdata", wr_data_log[wr0 + k], wdata[k]);
            end
            shadow[t.data_addr] = wdata;
        end
        if (errors == err0) begin
            $display("test %0d: ok", idx);
        end else begin
            $display("test %0d: %0d errors", idx, errors - err0);
            failed++;
        end
    endtask

    initial begin
        rst      = 1'b1;
        flush    = 1'b0;
        ready    = 1'b1;
        insn_req = '0;
        data_req = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        if ({bmem_cmd.read, bmem_cmd.write, insn_rsp.resp, data_rsp.resp} !== 4'h0) begin
            $display("[ERROR] o_bmem_cmd.read/write, o_insn/data_rsp.resp: got %h expected %h",
                     {bmem_cmd.read, bmem_cmd.write, insn_rsp.resp, data_rsp.resp}, 4'h0);
            errors++;
        end
        for (int i = 0; i < N_TESTS && !timed_out; i++) begin
            run_test(i, tests[i]);
        end
        $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 n_run, n_run - failed, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/dram_pkg.sv
source/line_pkg.sv
source/line_arbiter.sv
source/burst_adaptor.sv
source/dram_line_port.sv
verification/bmem_model.sv
verification/tb_dram_line_port.sv

/* run.sh */
#!/bin/sh
# compile and run the line port testbench under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dram_line_port \
    -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_dram_line_port > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
